// ==== include/hps_link_macros.svh ====
`ifndef HPS_LINK_MACROS_SVH
`define HPS_LINK_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// user I/O channel commands
//////////////////////////////////////////////////////////////////////

// config word, buttons and video switches
`define HPS_CMD_CFG        16'h0001
`define HPS_CMD_JOY0       16'h0002
`define HPS_CMD_JOY1       16'h0003
// config string read back
`define HPS_CMD_CONF_STR   16'h0014
`define HPS_CMD_STATUS     16'h001E
// core asks the host to take a new status
`define HPS_CMD_STATUS_SET 16'h0029

//////////////////////////////////////////////////////////////////////
// file channel commands
//////////////////////////////////////////////////////////////////////

`define HPS_FIO_TX         16'h0053
`define HPS_FIO_TX_DAT     16'h0054
`define HPS_FIO_INDEX      16'h0055

// menu string, first character at the highest byte
`define HPS_CONF_STR       "HPS_DEMO;;J,Fire;"
`define HPS_CONF_LEN       17

// upper nibble of the status-set reply
`define HPS_STATUS_SET_TAG 4'hA

`endif

// ==== rtl/hps_link_pkg.sv ====
package hps_link_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus and core side widths
	//////////////////////////////////////////////////////////////////////

	// one word on the host bus
	typedef logic [15:0] hps_word_t;

	// up to 32 buttons per joystick
	typedef logic [31:0] joy_buttons_t;

	// core status, written in four words
	typedef logic [63:0] core_status_t;

	// byte address of a download
	typedef logic [26:0] ioctl_addr_t;

	//////////////////////////////////////////////////////////////////////
	// config string and counters
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] conf_char_t;

	// word index inside a transaction, saturates at all ones
	typedef logic [5:0] word_cnt_t;

	typedef logic [4:0] conf_addr_t;

	// file channel, command word first and then its arguments
	typedef enum logic {
		FIO_WAIT_CMD,
		FIO_ARGS
	} fio_phase_e;

endpackage

// ==== rtl/conf_string_rom.sv ====
`timescale 1ns/100ps

`include "hps_link_macros.svh"

module conf_string_rom import hps_link_pkg::*; (
	input  logic       clk_sys,
	input  conf_addr_t conf_addr,
	output conf_char_t conf_char
);

	localparam logic [`HPS_CONF_LEN*8-1:0] CONF_BITS = `HPS_CONF_STR;

	conf_char_t rom [`HPS_CONF_LEN];

	// string literal keeps its first character in the top byte
	initial begin
		for (int i = 0; i < `HPS_CONF_LEN; i++) begin
			rom[i] = CONF_BITS[((`HPS_CONF_LEN - i) * 8) - 1 -: 8];
		end
	end

	// past the end of the string reads as zero
	always_ff @(posedge clk_sys) begin
		if (conf_addr < `HPS_CONF_LEN) begin
			conf_char <= rom[conf_addr];
		end else begin
			conf_char <= '0;
		end
	end

endmodule

// ==== rtl/uio_channel.sv ====
`timescale 1ns/100ps

`include "hps_link_macros.svh"

module uio_channel import hps_link_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         io_enable,
	input  logic         io_strobe,
	input  hps_word_t    io_din,
	output hps_word_t    io_dout,

	// config string ROM, one cycle read latency
	output conf_addr_t   conf_addr,
	input  conf_char_t   conf_char,

	output joy_buttons_t joystick_0,
	output joy_buttons_t joystick_1,
	output logic [1:0]   buttons,
	output logic         forced_scandoubler,
	output logic         direct_video,
	output core_status_t status,
	input  core_status_t status_in,
	input  logic         status_set
);

	word_cnt_t    word_cnt;
	hps_word_t    cmd;

	// status-set request from the core
	logic         status_set_d;
	logic [3:0]   set_cnt;
	core_status_t status_req;

	// word k reads character k-1, address settles before the strobe
	assign conf_addr = conf_addr_t'(word_cnt - 1'b1);

	//////////////////////////////////////////////////////////////////////
	// status-set edge capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_d <= 1'b0;
			set_cnt <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				set_cnt <= set_cnt + 1'b1;
			end
		end
	end

	// snapshot of status_in for the host to fetch
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d) begin
			status_req <= status_in;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command engine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word_cnt <= '0;
			cmd <= '0;
			io_dout <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			buttons <= '0;
			forced_scandoubler <= 1'b0;
			direct_video <= 1'b0;
			status <= '0;
		end else if (!io_enable) begin
			// transaction over, get ready for the next command
			word_cnt <= '0;
			cmd <= '0;
			io_dout <= '0;
		end else if (io_strobe) begin
			io_dout <= '0;
			if (!(&word_cnt)) begin
				word_cnt <= word_cnt + 1'b1;
			end

			if (word_cnt == '0) begin
				cmd <= io_din;
				// only status-set answers on the command word
				if (io_din == `HPS_CMD_STATUS_SET) begin
					io_dout <= {4'h0, `HPS_STATUS_SET_TAG, 4'h0, set_cnt};
				end
			end else begin
				case (cmd)
					`HPS_CMD_CFG: begin
						buttons <= io_din[1:0];
						forced_scandoubler <= io_din[4];
						direct_video <= io_din[10];
					end

					// low half first, then high half
					`HPS_CMD_JOY0: begin
						if (word_cnt == 6'd1) begin
							joystick_0[15:0] <= io_din;
						end else if (word_cnt == 6'd2) begin
							joystick_0[31:16] <= io_din;
						end
					end

					`HPS_CMD_JOY1: begin
						if (word_cnt == 6'd1) begin
							joystick_1[15:0] <= io_din;
						end else if (word_cnt == 6'd2) begin
							joystick_1[31:16] <= io_din;
						end
					end

					`HPS_CMD_CONF_STR: begin
						if (word_cnt <= `HPS_CONF_LEN) begin
							io_dout <= {8'h00, conf_char};
						end
					end

					`HPS_CMD_STATUS: begin
						case (word_cnt)
							6'd1: status[15:0] <= io_din;
							6'd2: status[31:16] <= io_din;
							6'd3: status[47:32] <= io_din;
							6'd4: status[63:48] <= io_din;
							default: ;
						endcase
					end

					// host reads back the captured status, low word first
					`HPS_CMD_STATUS_SET: begin
						case (word_cnt)
							6'd1: io_dout <= status_req[15:0];
							6'd2: io_dout <= status_req[31:16];
							6'd3: io_dout <= status_req[47:32];
							6'd4: io_dout <= status_req[63:48];
							default: ;
						endcase
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/file_transfer.sv ====
`timescale 1ns/100ps

`include "hps_link_macros.svh"

module file_transfer import hps_link_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        fp_enable,
	input  logic        io_strobe,
	input  hps_word_t   io_din,
	output hps_word_t   ioctl_index,
	output logic        ioctl_download,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output hps_word_t   ioctl_dout
);

	fio_phase_e  phase;
	hps_word_t   cmd;
	word_cnt_t   arg_cnt;

	// running address of the next data word
	ioctl_addr_t addr;

	// write strobe, one cycle behind the data
	logic        wr_pend;

	//////////////////////////////////////////////////////////////////////
	// phase and control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= FIO_WAIT_CMD;
			arg_cnt <= '0;
			ioctl_download <= 1'b0;
			wr_pend <= 1'b0;
			ioctl_wr <= 1'b0;
		end else begin
			ioctl_wr <= wr_pend;
			wr_pend <= 1'b0;

			if (!fp_enable) begin
				phase <= FIO_WAIT_CMD;
			end else if (io_strobe) begin
				case (phase)
					FIO_WAIT_CMD: begin
						phase <= FIO_ARGS;
						arg_cnt <= '0;
					end
					FIO_ARGS: begin
						if (!(&arg_cnt)) begin
							arg_cnt <= arg_cnt + 1'b1;
						end
						if (cmd == `HPS_FIO_TX && arg_cnt == '0) begin
							ioctl_download <= (io_din[7:0] != 8'h00);
						end
						if (cmd == `HPS_FIO_TX_DAT && ioctl_download) begin
							wr_pend <= 1'b1;
						end
					end
					default: phase <= FIO_WAIT_CMD;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// command, index, address and data
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (fp_enable && io_strobe) begin
			if (phase == FIO_WAIT_CMD) begin
				cmd <= io_din;
			end else begin
				case (cmd)
					`HPS_FIO_INDEX: ioctl_index <= io_din;

					`HPS_FIO_TX: begin
						case (arg_cnt)
							// start from zero unless an address follows
							6'd0: if (io_din[7:0] != 8'h00) addr <= '0;
							6'd1: begin
								addr[15:0] <= io_din;
								ioctl_addr[15:0] <= io_din;
							end
							6'd2: begin
								addr[26:16] <= io_din[10:0];
								ioctl_addr[26:16] <= io_din[10:0];
							end
							default: ;
						endcase
					end

					// 16-bit words, byte address steps by two
					`HPS_FIO_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_addr <= addr;
							ioctl_dout <= io_din;
							addr <= addr + 27'd2;
						end
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/hps_link_top.sv ====
`timescale 1ns/100ps

module hps_link_top import hps_link_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,

	// host bus
	input  logic         io_enable,
	input  logic         fp_enable,
	input  logic         io_strobe,
	input  hps_word_t    io_din,
	output hps_word_t    io_dout,
	output logic         io_wait,

	// user I/O towards the core
	output joy_buttons_t joystick_0,
	output joy_buttons_t joystick_1,
	output logic [1:0]   buttons,
	output logic         forced_scandoubler,
	output logic         direct_video,
	output core_status_t status,
	input  core_status_t status_in,
	input  logic         status_set,

	// download towards the core
	output hps_word_t    ioctl_index,
	output logic         ioctl_download,
	output logic         ioctl_wr,
	output ioctl_addr_t  ioctl_addr,
	output hps_word_t    ioctl_dout,
	input  logic         ioctl_wait
);

	hps_word_t  uio_dout;
	conf_addr_t conf_addr;
	conf_char_t conf_char;

	// the core throttles the host directly
	assign io_wait = ioctl_wait;

	// only the user channel answers, the file channel never reads back
	assign io_dout = uio_dout;

	uio_channel uio_channel (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (uio_dout),
		.conf_addr          (conf_addr),
		.conf_char          (conf_char),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set)
	);

	conf_string_rom conf_string_rom (
		.clk_sys   (clk_sys),
		.conf_addr (conf_addr),
		.conf_char (conf_char)
	);

	file_transfer file_transfer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.fp_enable      (fp_enable),
		.io_strobe      (io_strobe),
		.io_din         (io_din),
		.ioctl_index    (ioctl_index),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== bench/hps_bus_host.sv ====
`timescale 1ns/100ps

module hps_bus_host import hps_link_pkg::*; (
	input  logic      clk_sys,
	output logic      io_enable,
	output logic      fp_enable,
	output logic      io_strobe,
	output hps_word_t io_din,
	input  hps_word_t io_dout,
	input  logic      io_wait
);

	// bus idle until the first transaction
	initial begin
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
	end

	// raise the enable of one channel, the file channel when file_ch is set
	task automatic open_channel(input logic file_ch);
		@(negedge clk_sys);
		io_enable = !file_ch;
		fp_enable = file_ch;
	endtask

	// one word per call, strobes come 4 cycles apart
	task automatic send_word(input hps_word_t din, output hps_word_t reply);
		@(negedge clk_sys);
		// file channel stalls while the core asks for wait
		while (fp_enable && io_wait) begin
			@(negedge clk_sys);
		end
		io_strobe = 1'b1;
		io_din = din;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		// reply was registered at the strobe edge
		reply = io_dout;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic close_channel();
		@(negedge clk_sys);
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din = '0;
		repeat (2) @(negedge clk_sys);
	endtask

endmodule

// ==== bench/hps_link_tb.sv ====
`timescale 1ns/100ps

`include "hps_link_macros.svh"

module hps_link_tb import hps_link_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int N_ROWS = 17;
	localparam int MAX_ARGS = 6;

	logic         clk_sys;
	logic         reset;
	logic         io_enable;
	logic         fp_enable;
	logic         io_strobe;
	hps_word_t    io_din;
	hps_word_t    io_dout;
	logic         io_wait;
	joy_buttons_t joystick_0;
	joy_buttons_t joystick_1;
	logic [1:0]   buttons;
	logic         forced_scandoubler;
	logic         direct_video;
	core_status_t status;
	core_status_t status_in;
	logic         status_set;
	hps_word_t    ioctl_index;
	logic         ioctl_download;
	logic         ioctl_wr;
	ioctl_addr_t  ioctl_addr;
	hps_word_t    ioctl_dout;
	logic         ioctl_wait;

	// stimulus table with one row per transaction
	string        t_name [N_ROWS];
	logic         t_file [N_ROWS];
	hps_word_t    t_cmd [N_ROWS];
	int           t_nargs [N_ROWS];
	hps_word_t    t_arg [N_ROWS][MAX_ARGS];
	hps_word_t    t_exp_word [N_ROWS];
	joy_buttons_t t_exp_joy [N_ROWS];
	core_status_t t_exp_status [N_ROWS];
	ioctl_addr_t  t_exp_addr [N_ROWS];
	logic         t_exp_bit [N_ROWS];
	int           t_wr_count [N_ROWS];
	int           t_set_edges [N_ROWS];

	ioctl_addr_t  wr_addr_q[$];
	hps_word_t    wr_data_q[$];
	int           seed;
	int           set_total;
	string        conf_text;

	hps_link_top dut0 (.*);

	hps_bus_host host0 (
		.clk_sys   (clk_sys),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.io_dout   (io_dout),
		.io_wait   (io_wait)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// every write pulse seen on the download port
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	initial begin
		#(N_ROWS * 8 * 4 * CLK_PERIOD + 50_000);
		$display("timeout: the transactions did not complete in the time allowed");
		abort_run();
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input hps_word_t expected,
			input hps_word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_joy(input string name, input joy_buttons_t expected,
			input joy_buttons_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_status(input string name, input core_status_t expected,
			input core_status_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input ioctl_addr_t expected,
			input ioctl_addr_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// table setup
	//////////////////////////////////////////////////////////////////////

	function automatic hps_word_t random_word();
		return hps_word_t'($random(seed));
	endfunction

	// arguments default to random words and rows override what matters
	task automatic add_row(input int r, input string name, input logic file_ch,
			input hps_word_t cmd, input int nargs);
		int i;
		t_name[r] = name;
		t_file[r] = file_ch;
		t_cmd[r] = cmd;
		t_nargs[r] = nargs;
		for (i = 0; i < MAX_ARGS; i++) begin
			t_arg[r][i] = random_word();
		end
		t_exp_word[r] = '0;
		t_exp_joy[r] = {t_arg[r][1], t_arg[r][0]};
		t_exp_status[r] = {t_arg[r][3], t_arg[r][2], t_arg[r][1], t_arg[r][0]};
		t_exp_addr[r] = '0;
		t_exp_bit[r] = 1'b0;
		t_wr_count[r] = 0;
		t_set_edges[r] = 0;
	endtask

	task automatic build_table();
		int r;
		conf_text = `HPS_CONF_STR;
		add_row(0, "cfg_all_ones", 1'b0, `HPS_CMD_CFG, 1);
		t_arg[0][0] = 16'hFFFF;
		t_exp_word[0] = 16'h0413;
		add_row(1, "cfg_mixed", 1'b0, `HPS_CMD_CFG, 1);
		t_arg[1][0] = 16'hF5EA;
		t_exp_word[1] = 16'h0402;
		add_row(2, "joy0_write", 1'b0, `HPS_CMD_JOY0, 2);
		add_row(3, "joy1_write", 1'b0, `HPS_CMD_JOY1, 2);
		add_row(4, "status_write", 1'b0, `HPS_CMD_STATUS, 4);
		add_row(5, "status_set_one", 1'b0, `HPS_CMD_STATUS_SET, 4);
		add_row(6, "status_set_three", 1'b0, `HPS_CMD_STATUS_SET, 4);
		add_row(7, "status_set_wrap", 1'b0, `HPS_CMD_STATUS_SET, 4);
		t_set_edges[5] = 1;
		t_set_edges[6] = 3;
		t_set_edges[7] = 14;
		// tag then four zero bits then the running edge count modulo 16
		for (r = 5; r <= 7; r++) begin
			set_total += t_set_edges[r];
			t_exp_word[r] = {4'h0, `HPS_STATUS_SET_TAG, 4'h0, set_total[3:0]};
		end
		add_row(8, "conf_string", 1'b0, `HPS_CMD_CONF_STR, `HPS_CONF_LEN + 2);
		add_row(9, "file_index", 1'b1, `HPS_FIO_INDEX, 1);
		t_exp_word[9] = t_arg[9][0];
		add_row(10, "dl_start_addr", 1'b1, `HPS_FIO_TX, 3);
		t_arg[10][0] = 16'h00FF;
		t_arg[10][1] = 16'h3456;
		t_arg[10][2] = 16'h0012;
		t_exp_bit[10] = 1'b1;
		add_row(11, "dl_data_addr", 1'b1, `HPS_FIO_TX_DAT, 5);
		t_exp_addr[11] = 27'h0123456;
		t_wr_count[11] = 5;
		// low byte zero stops the download
		add_row(12, "dl_stop", 1'b1, `HPS_FIO_TX, 1);
		t_arg[12][0] = 16'hAB00;
		add_row(13, "dl_data_idle", 1'b1, `HPS_FIO_TX_DAT, 3);
		add_row(14, "dl_start_zero", 1'b1, `HPS_FIO_TX, 1);
		t_arg[14][0] = 16'h0001;
		t_exp_bit[14] = 1'b1;
		add_row(15, "dl_data_zero", 1'b1, `HPS_FIO_TX_DAT, 6);
		t_wr_count[15] = 6;
		add_row(16, "dl_stop_end", 1'b1, `HPS_FIO_TX, 1);
		t_arg[16][0] = 16'h0000;
	endtask

	//////////////////////////////////////////////////////////////////////
	// applying one row
	//////////////////////////////////////////////////////////////////////

	function automatic hps_word_t expected_reply(input int r, input int k);
		hps_word_t result;
		result = '0;
		if (!t_file[r] && t_cmd[r] == `HPS_CMD_STATUS_SET) begin
			if (k == 0) result = t_exp_word[r];
			else if (k <= 4) result = t_exp_status[r][(k - 1) * 16 +: 16];
		end else if (!t_file[r] && t_cmd[r] == `HPS_CMD_CONF_STR) begin
			if (k >= 1 && k <= `HPS_CONF_LEN) result = {8'h00, conf_text[k - 1]};
		end
		return result;
	endfunction

	task automatic pulse_status_set();
		@(negedge clk_sys);
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
	endtask

	task automatic check_results(input int r);
		int n;
		if (t_file[r]) begin
			case (t_cmd[r])
				`HPS_FIO_INDEX: check_word(t_name[r], t_exp_word[r], ioctl_index);
				`HPS_FIO_TX: check_bit(t_name[r], t_exp_bit[r], ioctl_download);
				default: ;
			endcase
		end else begin
			case (t_cmd[r])
				`HPS_CMD_CFG: check_word(t_name[r], t_exp_word[r],
					{5'b0, direct_video, 5'b0, forced_scandoubler, 2'b0, buttons});
				`HPS_CMD_JOY0: check_joy(t_name[r], t_exp_joy[r], joystick_0);
				`HPS_CMD_JOY1: check_joy(t_name[r], t_exp_joy[r], joystick_1);
				`HPS_CMD_STATUS: check_status(t_name[r], t_exp_status[r], status);
				default: ;
			endcase
		end
		// most rows expect no write pulse at all
		if (wr_addr_q.size() != t_wr_count[r]) begin
			$display("%s: the download made %0d write pulses where %0d were expected",
				t_name[r], wr_addr_q.size(), t_wr_count[r]);
			abort_run();
		end
		for (n = 0; n < t_wr_count[r]; n++) begin
			check_addr(t_name[r], t_exp_addr[r] + ioctl_addr_t'(2 * n), wr_addr_q[n]);
			check_word(t_name[r], t_arg[r][n], wr_data_q[n]);
		end
		wr_addr_q.delete();
		wr_data_q.delete();
	endtask

	task automatic run_row(input int r);
		hps_word_t din;
		hps_word_t reply;
		int k;
		status_in = t_exp_status[r];
		repeat (t_set_edges[r]) pulse_status_set();
		// the reply has to come from the snapshot and not from the live input
		status_in = ~t_exp_status[r];
		host0.open_channel(t_file[r]);
		for (k = 0; k <= t_nargs[r]; k++) begin
			if (k == 0) din = t_cmd[r];
			else if (k <= MAX_ARGS) din = t_arg[r][k - 1];
			else din = '0;
			host0.send_word(din, reply);
			check_word(t_name[r], expected_reply(r, k), reply);
		end
		host0.close_channel();
		// reply cleared once the enable is gone
		check_word(t_name[r], '0, io_dout);
		check_results(r);
	endtask

	initial begin
		int row;
		seed = 32'hbd67;
		set_total = 0;
		reset = 1'b1;
		status_in = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		build_table();
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_status("after_reset", '0, status);
		check_joy("after_reset", '0, joystick_0);
		check_joy("after_reset", '0, joystick_1);
		check_word("after_reset", '0,
			{5'b0, direct_video, 5'b0, forced_scandoubler, 2'b0, buttons});
		check_bit("after_reset", 1'b0, ioctl_download);
		check_word("after_reset", '0, io_dout);
		for (row = 0; row < N_ROWS; row++) begin
			run_row(row);
		end
		// core back-pressure reaches the host directly
		ioctl_wait = 1'b1;
		@(negedge clk_sys);
		check_bit("io_wait_high", 1'b1, io_wait);
		ioctl_wait = 1'b0;
		@(negedge clk_sys);
		check_bit("io_wait_low", 1'b0, io_wait);
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== hps_link.f ====
+incdir+include
rtl/hps_link_pkg.sv
rtl/conf_string_rom.sv
rtl/uio_channel.sv
rtl/file_transfer.sv
rtl/hps_link_top.sv
bench/hps_bus_host.sv
bench/hps_link_tb.sv
